// ==== exe_stimulus.txt ====
# op kind fwd_a fwd_b flags curr_pc next_pc rs1 rs2 imm wb_data irq irq_data acc
# exp_result exp_store exp_taken exp_target (flags: 0 use_imm 1 lui 2 random 3 rdi 4 sac 5 mem_wr 6 reg_wr 7 rd_en)
0 0 0 0 40 00001000 00001004 00000005 00000003 00000010 00000000 0 00000000 0 00000008 00000003 0 00001020
8 0 0 0 40 00001000 00001004 00000003 00000005 00000010 00000000 0 00000000 0 fffffffe 00000005 0 00001020
1 0 0 0 40 00001000 00001004 00000001 00000024 00000010 00000000 0 00000000 0 00000010 00000024 0 00001020
2 0 0 0 40 00001000 00001004 ffffffff 00000001 00000010 00000000 0 00000000 0 00000001 00000001 0 00001020
3 0 0 0 40 00001000 00001004 ffffffff 00000001 00000010 00000000 0 00000000 0 00000000 00000001 0 00001020
4 0 0 0 40 00001000 00001004 f0f0f0f0 0ff00ff0 00000010 00000000 0 00000000 0 ff00ff00 0ff00ff0 0 00001020
5 0 0 0 40 00001000 00001004 80000000 00000004 00000010 00000000 0 00000000 0 08000000 00000004 0 00001020
d 0 0 0 40 00001000 00001004 80000000 00000004 00000010 00000000 0 00000000 0 f8000000 00000004 0 00001020
6 0 0 0 40 00001000 00001004 000000f0 00000f00 00000010 00000000 0 00000000 0 00000ff0 00000f00 0 00001020
7 0 0 0 40 00001000 00001004 00000ff0 000000f0 00000010 00000000 0 00000000 0 000000f0 000000f0 0 00001020
0 0 0 0 41 00001000 00001004 00000100 00000007 00000020 00000000 0 00000000 0 00000120 00000007 0 00001040
0 0 0 0 42 00001000 00001004 00000005 00000006 12345000 00000000 0 00000000 0 12345000 00000006 0 2468b000
0 0 1 0 40 00001000 00001004 0000dead 00000002 00000010 00000040 0 00000000 0 00000042 00000002 0 00001020
0 0 0 1 40 00001000 00001004 00000003 00000999 00000010 00000050 0 00000000 0 00000053 00000050 0 00001020
0 0 2 0 40 00001000 00001004 00000777 00000001 00000010 00000000 0 00000000 0 00000054 00000001 0 00001020
0 0 0 2 40 00001000 00001004 00000010 00000888 00000010 00000000 0 00000000 0 00000064 00000054 0 00001020
0 1 0 0 20 00001000 00001004 00000007 00000007 00000008 00000000 0 00000000 0 0000000e 00000007 1 00001010
0 1 0 0 20 00001000 00001004 00000007 00000008 00000008 00000000 0 00000000 0 0000000f 00000008 0 00001010
0 2 0 0 20 00001000 00001004 00000007 00000008 00000008 00000000 0 00000000 0 0000000f 00000008 1 00001010
0 3 0 0 20 00001000 00001004 fffffffe 00000001 00000008 00000000 0 00000000 0 ffffffff 00000001 1 00001010
0 4 0 0 20 00001000 00001004 fffffffe 00000001 00000008 00000000 0 00000000 0 ffffffff 00000001 0 00001010
0 5 0 0 20 00001000 00001004 fffffffe 00000001 00000008 00000000 0 00000000 0 ffffffff 00000001 0 00001010
0 6 0 0 20 00001000 00001004 fffffffe 00000001 00000008 00000000 0 00000000 0 ffffffff 00000001 1 00001010
0 7 0 0 40 00001000 00001004 00000000 00000000 00000100 00000000 0 00000000 0 00000000 00000000 1 00001200
0 8 0 0 40 00001000 00001004 00002000 00000000 00000010 00000000 0 00000000 0 00002000 00000000 1 00002010
0 0 0 0 44 00001000 00001004 00000001 00000001 00000010 00000000 0 00000000 0 00000000 00000001 0 00001020
0 0 0 0 40 00001000 00001004 00000001 00000001 00000010 00000000 0 00000000 0 00000002 00000001 0 00001020
0 0 0 0 44 00001000 00001004 00000001 00000001 00000010 00000000 0 00000000 0 00000000 00000001 0 00001020
0 0 0 0 44 00001000 00001004 00000001 00000001 00000010 00000000 0 00000000 0 00000000 00000001 0 00001020
0 0 0 0 48 00001000 00001004 00000001 00000001 00000010 00000000 1 cafef00d 0 cafef00d 00000001 0 00001020
0 0 0 0 4c 00001000 00001004 00000001 00000001 00000010 00000000 1 12345678 0 12345678 00000001 0 00001020
0 0 0 0 5c 00001000 00001004 00000001 00000001 00000010 00000000 0 00000000 1 00000001 00000001 0 00001020
0 0 0 0 50 00001000 00001004 00000001 00000001 00000010 00000000 0 00000000 0 00000000 00000001 0 00001020
0 0 0 0 e0 00001000 00001004 00000002 00000002 00000010 00000000 0 00000000 0 00000004 00000002 0 00001020

// ==== all.f ====
+incdir+.
isa_pkg.sv
pipe_pkg.sv
alu.sv
branch_unit.sv
lfsr_rng.sv
execute_stage.sv
exe_top.sv
tb_exe_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f all.f --top-module tb_exe_top -o tb_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_sim; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation finished"
exit 0

// ==== tb_exe_top.sv ====
`timescale 1ns/1ps

`include "exe_macros.svh"

module tb_exe_top;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int TIMEOUT = 200;
    localparam logic [`SEED_W-1:0] RNG_SEED = 10'h2b7;

    logic clk;
    logic rst_n;
    logic [`SEED_W-1:0] seed;
    logic in_valid, in_ready, out_valid, out_ready;
    word_t next_pc, curr_pc, rs1_data, rs2_data, imm, wb_data, rdi_data;
    alu_op_t alu_op;
    bj_kind_t bj_kind;
    fwd_sel_t fwd_a, fwd_b;
    logic use_imm, lui, random, rdi, sac, ld_unsigned, irq, acc_bit;
    logic mem_wr_en, reg_wr_en, rd_en;
    wb_sel_t wb_sel;
    ld_width_t ld_width;
    reg_addr_t rd;
    logic branch_taken;
    word_t branch_target, iface_data, next_pc_m, alu_result_m, store_data_m;
    wb_sel_t wb_sel_m;
    ld_width_t ld_width_m;
    logic ld_unsigned_m, mem_wr_en_m, reg_wr_en_m, rd_en_m;
    reg_addr_t rd_m;

    logic [31:0] rng_state;
    logic [`LFSR_W-1:0] lfsr_model;
    logic [31:0] prev_res;
    logic [31:0] f_op, f_kind, f_fa, f_fb, f_flags, f_cpc, f_npc, f_rs1, f_rs2, f_imm;
    logic [31:0] f_wbd, f_irq, f_irqd, f_acc, f_res, f_st, f_tk, f_tgt;
    int line_no;

    exe_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Fibonacci step with taps at bits 15, 14, 12 and 3
    function automatic logic [`LFSR_W-1:0] lfsr_next(input logic [`LFSR_W-1:0] s);
        logic fb;
        fb = s[15] ^ s[14] ^ s[12] ^ s[3];
        return {s[`LFSR_W-2:0], fb};
    endfunction

    // Memory side back-pressure
    always @(posedge clk) begin
        rng_state = xorshift32(rng_state);
        out_ready <= rng_state[0];
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] time %0t %s got %h expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s on line %0d", what, line_no);
        $display("sim failed");
        $fatal(1, "timeout");
    endtask

    // Inverted inputs while the slot is held, so it must keep its own copy
    task automatic disturb_inputs();
        next_pc     <= ~f_npc;
        curr_pc     <= ~f_cpc;
        rs1_data    <= ~f_rs1;
        rs2_data    <= ~f_rs2;
        imm         <= ~f_imm;
        wb_data     <= ~f_wbd;
        rd          <= ~line_no[4:0];
        wb_sel      <= ~line_no[1:0];
        ld_width    <= ~line_no[3:2];
        ld_unsigned <= ~line_no[0];
        mem_wr_en   <= ~f_flags[5];
        reg_wr_en   <= ~f_flags[6];
        rd_en       <= ~f_flags[7];
        acc_bit     <= ~f_acc[0];
    endtask

    task automatic check_outputs(input logic [31:0] exp_res);
        check_value("next_pc_m", next_pc_m, f_npc);
        check_value("alu_result_m", alu_result_m, exp_res);
        check_value("store_data_m", store_data_m, f_st);
        check_value("rd_m", 32'(rd_m), 32'(line_no[4:0]));
        check_value("wb_sel_m", 32'(wb_sel_m), 32'(line_no[1:0]));
        check_value("ld_width_m", 32'(ld_width_m), 32'(line_no[3:2]));
        check_value("ld_unsigned_m", 32'(ld_unsigned_m), 32'(line_no[0]));
        check_value("mem_wr_en_m", 32'(mem_wr_en_m), 32'(f_flags[5]));
        check_value("reg_wr_en_m", 32'(reg_wr_en_m), 32'(f_flags[6]));
        check_value("rd_en_m", 32'(rd_en_m), 32'(f_flags[7]));
    endtask

    task automatic run_line();
        int cnt;
        logic [31:0] exp_res;
        logic [31:0] exp_op_a;
        @(posedge clk);
        if (f_irq[0]) begin
            irq      <= 1'b1;
            rdi_data <= f_irqd;
            @(posedge clk);
            irq <= 1'b0;
        end
        in_valid    <= 1'b1;
        alu_op      <= f_op[3:0];
        bj_kind     <= f_kind[3:0];
        fwd_a       <= f_fa[1:0];
        fwd_b       <= f_fb[1:0];
        use_imm     <= f_flags[0];
        lui         <= f_flags[1];
        random      <= f_flags[2];
        rdi         <= f_flags[3];
        sac         <= f_flags[4];
        mem_wr_en   <= f_flags[5];
        reg_wr_en   <= f_flags[6];
        rd_en       <= f_flags[7];
        curr_pc     <= f_cpc;
        next_pc     <= f_npc;
        rs1_data    <= f_rs1;
        rs2_data    <= f_rs2;
        imm         <= f_imm;
        wb_data     <= f_wbd;
        acc_bit     <= f_acc[0];
        rd          <= line_no[4:0];
        wb_sel      <= line_no[1:0];
        ld_width    <= line_no[3:2];
        ld_unsigned <= line_no[0];
        // Operand A as forwarding should pick it
        case (f_fa[1:0])
            2'd1:    exp_op_a = f_wbd;
            2'd2:    exp_op_a = prev_res;
            default: exp_op_a = f_rs1;
        endcase
        @(negedge clk);
        check_value("iface_data", iface_data, exp_op_a);
        check_value("branch_taken", 32'(branch_taken), f_tk);
        check_value("branch_target", branch_target, f_tgt);
        cnt = 0;
        while (!in_ready) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("in_ready");
        end
        // Random byte is the state before this instruction's step
        exp_res = f_res;
        if (f_flags[2]) begin
            if (!f_flags[3] && !f_flags[4]) exp_res = {24'd0, lfsr_model[7:0]};
            lfsr_model = lfsr_next(lfsr_model);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        disturb_inputs();
        // Slot must hold its value every cycle until memory takes it
        cnt = 0;
        @(negedge clk);
        while (!(out_valid && out_ready)) begin
            if (out_valid) check_outputs(exp_res);
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) report_timeout("out_valid and out_ready");
        end
        check_outputs(exp_res);
        prev_res = exp_res;
        @(posedge clk);
        @(negedge clk);
        check_value("out_valid after drain", 32'(out_valid), 32'd0);
    endtask

    initial begin
        int fd;
        int n;
        string line;
        rng_state = 32'hed600163;
        rst_n = 1'b0;
        seed = RNG_SEED;
        in_valid = 1'b0;
        out_ready = 1'b0;
        next_pc = '0;
        curr_pc = '0;
        rs1_data = '0;
        rs2_data = '0;
        imm = '0;
        wb_data = '0;
        rdi_data = '0;
        alu_op = ALU_ADD;
        bj_kind = BJ_NONE;
        fwd_a = FWD_RF;
        fwd_b = FWD_RF;
        use_imm = 1'b0;
        lui = 1'b0;
        random = 1'b0;
        rdi = 1'b0;
        sac = 1'b0;
        wb_sel = 2'd1;
        ld_width = 2'd2;
        ld_unsigned = 1'b0;
        rd = '0;
        mem_wr_en = 1'b0;
        reg_wr_en = 1'b0;
        rd_en = 1'b0;
        irq = 1'b0;
        acc_bit = 1'b0;
        line_no = 0;
        prev_res = '0;
        lfsr_model = {RNG_SEED, `LFSR_LOW};
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("mem_wr_en_m", 32'(mem_wr_en_m), 32'd0);
        check_value("reg_wr_en_m", 32'(reg_wr_en_m), 32'd0);
        check_value("rd_en_m", 32'(rd_en_m), 32'd0);
        fd = $fopen("exe_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            $display("sim failed");
            $fatal(1, "no stimulus");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f_op, f_kind, f_fa, f_fb, f_flags, f_cpc, f_npc, f_rs1, f_rs2,
                        f_imm, f_wbd, f_irq, f_irqd, f_acc, f_res, f_st, f_tk, f_tgt);
            if (n == 18) begin
                line_no++;
                run_line();
            end
        end
        $fclose(fd);
        if (line_no == 0) begin
            $display("The stimulus file held no instructions");
            $display("sim failed");
            $fatal(1, "empty stimulus");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

// ==== exe_top.sv ====
`timescale 1ns/1ps

`include "exe_macros.svh"

module exe_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [`SEED_W-1:0]  seed,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                out_valid,
    input  logic                out_ready,
    input  pipe_pkg::word_t     next_pc,
    input  pipe_pkg::word_t     curr_pc,
    input  pipe_pkg::word_t     rs1_data,
    input  pipe_pkg::word_t     rs2_data,
    input  pipe_pkg::word_t     imm,
    input  isa_pkg::alu_op_t    alu_op,
    input  isa_pkg::bj_kind_t   bj_kind,
    input  pipe_pkg::fwd_sel_t  fwd_a,
    input  pipe_pkg::fwd_sel_t  fwd_b,
    input  pipe_pkg::word_t     wb_data,
    input  logic                use_imm,
    input  logic                lui,
    input  logic                random,
    input  logic                rdi,
    input  logic                sac,
    input  pipe_pkg::wb_sel_t   wb_sel,
    input  pipe_pkg::ld_width_t ld_width,
    input  logic                ld_unsigned,
    input  pipe_pkg::reg_addr_t rd,
    input  logic                mem_wr_en,
    input  logic                reg_wr_en,
    input  logic                rd_en,
    input  logic                irq,
    input  pipe_pkg::word_t     rdi_data,
    input  logic                acc_bit,
    output logic                branch_taken,
    output pipe_pkg::word_t     branch_target,
    output pipe_pkg::word_t     iface_data,
    output pipe_pkg::word_t     next_pc_m,
    output pipe_pkg::word_t     alu_result_m,
    output pipe_pkg::word_t     store_data_m,
    output pipe_pkg::wb_sel_t   wb_sel_m,
    output pipe_pkg::ld_width_t ld_width_m,
    output logic                ld_unsigned_m,
    output pipe_pkg::reg_addr_t rd_m,
    output logic                mem_wr_en_m,
    output logic                reg_wr_en_m,
    output logic                rd_en_m
);

    logic [7:0] rand_byte;
    logic       lfsr_step;

    // Random source steps only for accepted random instructions
    lfsr_rng u_rng (
        .clk       (clk),
        .rst_n     (rst_n),
        .seed      (seed),
        .step      (lfsr_step),
        .rand_byte (rand_byte)
    );

    execute_stage u_exe (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .next_pc       (next_pc),
        .curr_pc       (curr_pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .imm           (imm),
        .alu_op        (alu_op),
        .bj_kind       (bj_kind),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .wb_data       (wb_data),
        .use_imm       (use_imm),
        .lui           (lui),
        .random        (random),
        .rdi           (rdi),
        .sac           (sac),
        .wb_sel        (wb_sel),
        .ld_width      (ld_width),
        .ld_unsigned   (ld_unsigned),
        .rd            (rd),
        .mem_wr_en     (mem_wr_en),
        .reg_wr_en     (reg_wr_en),
        .rd_en         (rd_en),
        .irq           (irq),
        .rdi_data      (rdi_data),
        .acc_bit       (acc_bit),
        .rand_byte     (rand_byte),
        .lfsr_step     (lfsr_step),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .iface_data    (iface_data),
        .next_pc_m     (next_pc_m),
        .alu_result_m  (alu_result_m),
        .store_data_m  (store_data_m),
        .wb_sel_m      (wb_sel_m),
        .ld_width_m    (ld_width_m),
        .ld_unsigned_m (ld_unsigned_m),
        .rd_m          (rd_m),
        .mem_wr_en_m   (mem_wr_en_m),
        .reg_wr_en_m   (reg_wr_en_m),
        .rd_en_m       (rd_en_m)
    );

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

`include "exe_macros.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    output logic                out_valid,
    input  logic                out_ready,
    input  pipe_pkg::word_t     next_pc,
    input  pipe_pkg::word_t     curr_pc,
    input  pipe_pkg::word_t     rs1_data,
    input  pipe_pkg::word_t     rs2_data,
    input  pipe_pkg::word_t     imm,
    input  isa_pkg::alu_op_t    alu_op,
    input  isa_pkg::bj_kind_t   bj_kind,
    input  pipe_pkg::fwd_sel_t  fwd_a,
    input  pipe_pkg::fwd_sel_t  fwd_b,
    input  pipe_pkg::word_t     wb_data,
    input  logic                use_imm,
    input  logic                lui,
    input  logic                random,
    input  logic                rdi,
    input  logic                sac,
    input  pipe_pkg::wb_sel_t   wb_sel,
    input  pipe_pkg::ld_width_t ld_width,
    input  logic                ld_unsigned,
    input  pipe_pkg::reg_addr_t rd,
    input  logic                mem_wr_en,
    input  logic                reg_wr_en,
    input  logic                rd_en,
    input  logic                irq,
    input  pipe_pkg::word_t     rdi_data,
    input  logic                acc_bit,
    input  logic [7:0]          rand_byte,
    output logic                lfsr_step,
    output logic                branch_taken,
    output pipe_pkg::word_t     branch_target,
    output pipe_pkg::word_t     iface_data,
    output pipe_pkg::word_t     next_pc_m,
    output pipe_pkg::word_t     alu_result_m,
    output pipe_pkg::word_t     store_data_m,
    output pipe_pkg::wb_sel_t   wb_sel_m,
    output pipe_pkg::ld_width_t ld_width_m,
    output logic                ld_unsigned_m,
    output pipe_pkg::reg_addr_t rd_m,
    output logic                mem_wr_en_m,
    output logic                reg_wr_en_m,
    output logic                rd_en_m
);

    import pipe_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_in_b;
    word_t alu_out;
    word_t base_result;
    word_t result;
    word_t rdi_q;
    logic  accept;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t rf, word_t wb, word_t ex);
        word_t val;
        case (sel)
            FWD_WB:  val = wb;
            FWD_EX:  val = ex;
            default: val = rf;
        endcase
        return val;
    endfunction

    // Operand forwarding
    assign op_a     = fwd_mux(fwd_a, rs1_data, wb_data, alu_result_m);
    assign op_b     = fwd_mux(fwd_b, rs2_data, wb_data, alu_result_m);
    assign alu_in_b = use_imm ? imm : op_b;

    assign iface_data = op_a;

    alu u_alu (
        .in_a   (op_a),
        .in_b   (alu_in_b),
        .op     (alu_op),
        .result (alu_out)
    );

    branch_unit u_branch (
        .kind   (bj_kind),
        .in_a   (op_a),
        .in_b   (alu_in_b),
        .pc     (curr_pc),
        .imm    (imm),
        .taken  (branch_taken),
        .target (branch_target)
    );

    // Interrupt data is captured whenever irq fires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdi_q <= '0;
        end else if (irq) begin
            rdi_q <= rdi_data;
        end
    end

    // Later overrides win: random, then rdi, then sac
    assign base_result = lui ? imm : alu_out;

    always_comb begin
        result = base_result;
        if (random) begin
            result = {{(`XLEN-8){1'b0}}, rand_byte};
        end
        if (rdi) begin
            result = rdi_q;
        end
        if (sac) begin
            result = {{(`XLEN-1){1'b0}}, acc_bit};
        end
    end

    // Stage register handshake
    assign in_ready  = !out_valid || out_ready;
    assign accept    = in_valid && in_ready;
    assign lfsr_step = accept && random;

    // Valid and enables, cleared when the slot drains empty
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            mem_wr_en_m <= 1'b0;
            reg_wr_en_m <= 1'b0;
            rd_en_m     <= 1'b0;
        end else if (in_ready) begin
            out_valid   <= in_valid;
            mem_wr_en_m <= in_valid && mem_wr_en;
            reg_wr_en_m <= in_valid && reg_wr_en;
            rd_en_m     <= in_valid && rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            next_pc_m     <= next_pc;
            alu_result_m  <= result;
            store_data_m  <= op_b;
            wb_sel_m      <= wb_sel;
            ld_width_m    <= ld_width;
            ld_unsigned_m <= ld_unsigned;
            rd_m          <= rd;
        end
    end

    // Memory side must see a frozen slot while it stalls
    hold_under_backpressure: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=>
            (out_valid && $stable(next_pc_m) && $stable(alu_result_m) &&
             $stable(store_data_m) && $stable(wb_sel_m) && $stable(ld_width_m) &&
             $stable(ld_unsigned_m) && $stable(rd_m) && $stable(mem_wr_en_m) &&
             $stable(reg_wr_en_m) && $stable(rd_en_m))
    );

endmodule

// ==== lfsr_rng.sv ====
`timescale 1ns/1ps

`include "exe_macros.svh"

module lfsr_rng (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [`SEED_W-1:0] seed,
    input  logic               step,
    output logic [7:0]         rand_byte
);

    logic [`LFSR_W-1:0] state;
    logic               feedback;

    // Taps 16, 15, 13 and 4 in one-based numbering
    assign feedback = state[15] ^ state[14] ^ state[12] ^ state[3];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= {seed, `LFSR_LOW};
        end else if (step) begin
            state <= {state[`LFSR_W-2:0], feedback};
        end
    end

    // Consumer sees the state from before the step
    assign rand_byte = state[7:0];

    // All zeros would lock the register up for good
    state_nonzero: assert property (@(posedge clk) disable iff (!rst_n) state != '0);

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ps

module branch_unit (
    input  isa_pkg::bj_kind_t kind,
    input  pipe_pkg::word_t   in_a,
    input  pipe_pkg::word_t   in_b,
    input  pipe_pkg::word_t   pc,
    input  pipe_pkg::word_t   imm,
    output logic              taken,
    output pipe_pkg::word_t   target
);

    import isa_pkg::*;

    always_comb begin
        case (kind)
            BJ_NONE: taken = 1'b0;
            BJ_BEQ:  taken = (in_a == in_b);
            BJ_BNE:  taken = (in_a != in_b);
            BJ_BLT:  taken = ($signed(in_a) < $signed(in_b));
            BJ_BGE:  taken = ($signed(in_a) >= $signed(in_b));
            BJ_BLTU: taken = (in_a < in_b);
            BJ_BGEU: taken = (in_a >= in_b);
            BJ_JAL:  taken = 1'b1;
            BJ_JALR: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jalr is register relative with a byte offset
    // The other kinds take a halfword offset from the current pc
    assign target = (kind == BJ_JALR) ? (in_a + imm) : (pc + (imm << 1));

    // Decode must never hand over an encoding outside the kind table
    always_comb begin
        assert ($isunknown(kind) || (kind <= BJ_JALR))
            else $error("branch_unit: undefined branch kind %0h", kind);
    end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

`include "exe_macros.svh"

module alu (
    input  pipe_pkg::word_t  in_a,
    input  pipe_pkg::word_t  in_b,
    input  isa_pkg::alu_op_t op,
    output pipe_pkg::word_t  result
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    word_t              sum;
    word_t              diff;
    word_t              srl_res;
    word_t              sra_res;
    logic               lt_signed;
    logic               lt_unsigned;

    // Only the low bits of operand B count as shift amount
    assign shamt = in_b[SHAMT_W-1:0];

    assign sum  = in_a + in_b;
    assign diff = in_a - in_b;

    assign srl_res = in_a >> shamt;
    assign sra_res = word_t'($signed(in_a) >>> shamt);

    assign lt_signed   = $signed(in_a) < $signed(in_b);
    assign lt_unsigned = in_a < in_b;

    // Decode on the function bits, the option bit picks the variant
    always_comb begin
        case ({1'b0, op[2:0]})
            ALU_ADD: begin
                result = (op == ALU_SUB) ? diff : sum;
            end
            ALU_SLL: begin
                result = in_a << shamt;
            end
            ALU_SLT: begin
                result = word_t'(lt_signed);
            end
            ALU_SLTU: begin
                result = word_t'(lt_unsigned);
            end
            ALU_XOR: begin
                result = in_a ^ in_b;
            end
            ALU_SRL: begin
                result = (op == ALU_SRA) ? sra_res : srl_res;
            end
            ALU_OR: begin
                result = in_a | in_b;
            end
            ALU_AND: begin
                result = in_a & in_b;
            end
            default: begin
                result = sum;
            end
        endcase
    end

endmodule

// ==== pipe_pkg.sv ====
`include "exe_macros.svh"

package pipe_pkg;

    // Data word on every operand and result path
    typedef logic [`XLEN-1:0] word_t;

    // Destination register index
    typedef logic [`REG_AW-1:0] reg_addr_t;

    // Writeback source select, decoded downstream
    typedef logic [1:0] wb_sel_t;

    // Load width, decoded in the memory stage
    typedef logic [1:0] ld_width_t;

    // Operand forwarding select
    typedef logic [1:0] fwd_sel_t;

    // Register file value
    localparam fwd_sel_t FWD_RF = 2'd0;

    // Data on its way back from writeback
    localparam fwd_sel_t FWD_WB = 2'd1;

    // Result held in the execute stage register
    localparam fwd_sel_t FWD_EX = 2'd2;

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

    // ALU operation, bits [2:0] select the function
    // Bit 3 is the option bit: add becomes sub, srl becomes sra
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD  = 4'b0000;
    localparam alu_op_t ALU_SLL  = 4'b0001;
    localparam alu_op_t ALU_SLT  = 4'b0010;
    localparam alu_op_t ALU_SLTU = 4'b0011;
    localparam alu_op_t ALU_XOR  = 4'b0100;
    localparam alu_op_t ALU_SRL  = 4'b0101;
    localparam alu_op_t ALU_OR   = 4'b0110;
    localparam alu_op_t ALU_AND  = 4'b0111;
    localparam alu_op_t ALU_SUB  = 4'b1000;
    localparam alu_op_t ALU_SRA  = 4'b1101;

    // Branch and jump kind
    typedef logic [3:0] bj_kind_t;

    localparam bj_kind_t BJ_NONE = 4'd0;
    localparam bj_kind_t BJ_BEQ  = 4'd1;
    localparam bj_kind_t BJ_BNE  = 4'd2;
    localparam bj_kind_t BJ_BLT  = 4'd3;
    localparam bj_kind_t BJ_BGE  = 4'd4;
    localparam bj_kind_t BJ_BLTU = 4'd5;
    localparam bj_kind_t BJ_BGEU = 4'd6;
    localparam bj_kind_t BJ_JAL  = 4'd7;
    localparam bj_kind_t BJ_JALR = 4'd8;

endpackage

// ==== exe_macros.svh ====
`ifndef EXE_MACROS_SVH
`define EXE_MACROS_SVH

// Data path width
`define XLEN 32

// Register file address width
`define REG_AW 5

// Random source state width
`define LFSR_W 16

// Seed bits loaded into the upper part of the LFSR at reset
`define SEED_W 10

// Fixed low bits of the LFSR reset value
// Nonzero so the state can never start at all zeros
`define LFSR_LOW 6'h2a

`endif
